/* tb.f */
common/core_pkg.sv
source/reg_file.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
source/hazard_unit.sv
source/mem_stage.sv
source/core.sv
bench/tb_mem.sv
bench/tb_core.sv

/* Makefile */
SRCS := $(wildcard common/*.sv fetch/*.sv decode/*.sv execute/*.sv source/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_core: tb.f $(SRCS)
	verilator --binary --timing --top-module tb_core -f tb.f -o Vtb_core

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core

clean:
	rm -rf obj_dir

/* bench/tb_core.sv */
`default_nettype none

module tb_core
	import core_pkg::*;
();

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
	// ten times the roughly 200 cycles that all programs take
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int HALT_STAY = 20;

	// mips encodings
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_LW    = 6'h23;
	localparam logic [5:0] OPC_SW    = 6'h2b;
	localparam logic [5:0] OPC_BEQ   = 6'h04;
	localparam logic [5:0] F_ADDU    = 6'h21;
	localparam logic [5:0] F_SUBU    = 6'h23;
	localparam logic [5:0] F_AND     = 6'h24;
	localparam logic [5:0] F_OR      = 6'h25;
	localparam logic [5:0] F_SLT     = 6'h2a;

	logic            clk;
	logic            arst_n;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] rdata;
	logic [XLEN-1:0] iaddr;
	logic [XLEN-1:0] daddr;
	logic [XLEN-1:0] wdata;
	logic            mem_write;
	logic            mem_read;
	int              cycles = 0;
	logic [XLEN-1:0] load_addr;
	logic [XLEN-1:0] halt_addr;
	logic [XLEN-1:0] exp_addr [$];
	logic [XLEN-1:0] exp_data [$];

	core #(.RESET_PC(RESET_PC)) uut (
		.i_clk(clk), .i_arst_n(arst_n), .i_instr(instr), .i_rdata(rdata),
		.o_iaddr(iaddr), .o_daddr(daddr), .o_wdata(wdata),
		.o_mem_write(mem_write), .o_mem_read(mem_read)
	);

	tb_mem u_mem (
		.i_clk(clk), .i_clear(!arst_n), .i_iaddr(iaddr), .o_instr(instr),
		.i_daddr(daddr), .i_wdata(wdata), .i_mem_write(mem_write),
		.i_mem_read(mem_read), .o_rdata(rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout, run not done after %0d cycles", cycles));
		end
	end

	task automatic stop_with_failure(string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] rtype(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_to(logic [31:0] target);
		return {6'h02, target[27:2]};
	endfunction

	function automatic logic [31:0] sign_extend(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// empty rom words are nops
	task automatic begin_program();
		for (int i = 0; i < 256; i++) begin
			u_mem.rom[i] = 32'h0;
		end
		exp_addr.delete();
		exp_data.delete();
		@(negedge clk);
		arst_n = 1'b0;
		load_addr = RESET_PC;
	endtask

	task automatic put(logic [31:0] word);
		u_mem.rom[load_addr[9:2]] = word;
		load_addr = load_addr + 32'd4;
	endtask

	task automatic put_halt();
		halt_addr = load_addr;
		put(jump_to(load_addr));
	endtask

	task automatic expect_store(logic [31:0] addr, logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_reset_outputs();
		check("o_iaddr", iaddr, RESET_PC);
		check("o_mem_write", 32'(mem_write), 32'h0);
		check("o_mem_read", 32'(mem_read), 32'h0);
	endtask

	task automatic release_reset();
		repeat (8) begin
			@(negedge clk);
			check_reset_outputs();
		end
		arst_n = 1'b1;
		check_reset_outputs();
		@(negedge clk);
		check("o_iaddr", iaddr, RESET_PC + 32'd4);
	endtask

	// halt loop spans the j and the two flushed words behind it
	task automatic finish_program(string name);
		int stay;
		stay = 0;
		while (stay < HALT_STAY) begin
			@(negedge clk);
			if (iaddr >= halt_addr && iaddr <= halt_addr + 32'd8) begin
				stay++;
			end else begin
				stay = 0;
			end
		end
		if (u_mem.log_count != exp_addr.size()) begin
			stop_with_failure($sformatf("%s test saw %0d stores but expected %0d",
				name, u_mem.log_count, exp_addr.size()));
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			check($sformatf("%s store %0d address", name, i), u_mem.log_addr[i], exp_addr[i]);
			check($sformatf("%s store %0d data", name, i), u_mem.log_data[i], exp_data[i]);
		end
	endtask

	task automatic reset_state_test();
		begin_program();
		put_halt();
		release_reset();
		finish_program("reset state");
	endtask

	task automatic alu_chain_test();
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		logic [31:0] v [9];
		logic [31:0] addr;
		imm_a = 16'($urandom) | 16'h8000;
		imm_b = 16'($urandom);
		v[0] = 32'h0;
		v[1] = sign_extend(imm_a);
		v[2] = v[1] + sign_extend(imm_b);
		v[3] = v[2] + v[1];
		v[4] = v[3] - v[2];
		v[5] = v[4] & v[3];
		v[6] = v[5] | v[4];
		v[7] = ($signed(v[6]) < $signed(v[5])) ? 32'd1 : 32'd0;
		v[8] = ($signed(v[1]) < $signed(v[0])) ? 32'd1 : 32'd0;
		begin_program();
		put(itype(OPC_ADDIU, 5'd0, 5'd1, imm_a));
		put(itype(OPC_ADDIU, 5'd1, 5'd2, imm_b));
		put(rtype(5'd2, 5'd1, 5'd3, F_ADDU));
		put(rtype(5'd3, 5'd2, 5'd4, F_SUBU));
		put(rtype(5'd4, 5'd3, 5'd5, F_AND));
		put(rtype(5'd5, 5'd4, 5'd6, F_OR));
		put(rtype(5'd6, 5'd5, 5'd7, F_SLT));
		put(rtype(5'd1, 5'd0, 5'd8, F_SLT));
		// newest result first so the store data is forwarded as well
		for (int r = 8; r >= 1; r--) begin
			addr = 32'h40 + 32'(4 * r);
			put(itype(OPC_SW, 5'd0, 5'(r), addr[15:0]));
			expect_store(addr, v[r]);
		end
		put_halt();
		release_reset();
		finish_program("alu chain");
	endtask

	task automatic load_use_test();
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		imm_a = 16'($urandom);
		imm_b = 16'($urandom);
		begin_program();
		put(itype(OPC_ADDIU, 5'd0, 5'd1, imm_a));
		put(itype(OPC_ADDIU, 5'd0, 5'd2, imm_b));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h0080));
		put(itype(OPC_LW, 5'd0, 5'd3, 16'h0080));
		put(rtype(5'd3, 5'd2, 5'd4, F_ADDU));
		put(itype(OPC_SW, 5'd0, 5'd4, 16'h0084));
		put(itype(OPC_LW, 5'd0, 5'd5, 16'h0080));
		put(itype(OPC_SW, 5'd0, 5'd5, 16'h0088));
		put_halt();
		expect_store(32'h80, sign_extend(imm_a));
		expect_store(32'h84, sign_extend(imm_a) + sign_extend(imm_b));
		expect_store(32'h88, sign_extend(imm_a));
		release_reset();
		finish_program("load use");
	endtask

	task automatic branch_test();
		logic [15:0] imm_a;
		imm_a = 16'($urandom);
		begin_program();
		put(itype(OPC_ADDIU, 5'd0, 5'd1, imm_a));
		put(itype(OPC_ADDIU, 5'd0, 5'd2, imm_a));
		// taken beq skips the two stores behind it
		put(itype(OPC_BEQ, 5'd1, 5'd2, 16'd2));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h00a0));
		put(itype(OPC_SW, 5'd0, 5'd2, 16'h00a4));
		put(itype(OPC_ADDIU, 5'd0, 5'd3, imm_a ^ 16'h0001));
		put(itype(OPC_BEQ, 5'd1, 5'd3, 16'd1));
		put(itype(OPC_SW, 5'd0, 5'd3, 16'h00a8));
		put_halt();
		expect_store(32'ha8, sign_extend(imm_a ^ 16'h0001));
		release_reset();
		finish_program("branch");
	endtask

	task automatic jump_test();
		logic [15:0] imm_a;
		imm_a = 16'($urandom);
		begin_program();
		put(itype(OPC_ADDIU, 5'd0, 5'd1, imm_a));
		put(jump_to(load_addr + 32'd12));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h00c0));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h00c4));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h00c8));
		put_halt();
		expect_store(32'hc8, sign_extend(imm_a));
		release_reset();
		finish_program("jump");
	endtask

	task automatic zero_reg_test();
		logic [15:0] imm_z;
		logic [15:0] imm_a;
		imm_z = 16'($urandom) | 16'h0001;
		imm_a = 16'($urandom);
		begin_program();
		put(itype(OPC_ADDIU, 5'd0, 5'd0, imm_z));
		put(itype(OPC_ADDIU, 5'd0, 5'd1, imm_a));
		put(rtype(5'd0, 5'd1, 5'd2, F_ADDU));
		put(itype(OPC_SW, 5'd0, 5'd0, 16'h00e0));
		put(itype(OPC_SW, 5'd0, 5'd1, 16'h00e4));
		put(itype(OPC_SW, 5'd0, 5'd2, 16'h00e8));
		put_halt();
		expect_store(32'he0, 32'h0);
		expect_store(32'he4, sign_extend(imm_a));
		expect_store(32'he8, sign_extend(imm_a));
		release_reset();
		finish_program("register zero");
	endtask

	initial begin
		arst_n = 1'b0;
		load_addr = RESET_PC;
		halt_addr = RESET_PC;
		void'($urandom(32'hbdc8));
		reset_state_test();
		alu_chain_test();
		load_use_test();
		branch_test();
		jump_test();
		zero_reg_test();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_mem.sv */
`default_nettype none

module tb_mem (
	input  logic        i_clk,
	input  logic        i_clear,
	input  logic [31:0] i_iaddr,
	output logic [31:0] o_instr,
	input  logic [31:0] i_daddr,
	input  logic [31:0] i_wdata,
	input  logic        i_mem_write,
	input  logic        i_mem_read,
	output logic [31:0] o_rdata
);

	localparam int LOG_DEPTH = 32;

	// rom is filled by the testbench while the core is held in reset
	logic [31:0] rom [256];
	logic [31:0] ram [256];
	logic [31:0] log_addr [LOG_DEPTH];
	logic [31:0] log_data [LOG_DEPTH];
	int          log_count = 0;

	// both ports answer in the same cycle, word index from bits 9:2
	assign o_instr = rom[i_iaddr[9:2]];
	assign o_rdata = i_mem_read ? ram[i_daddr[9:2]] : 32'h0;

	always @(posedge i_clk) begin
		if (i_clear) begin
			log_count <= 0;
			for (int i = 0; i < 256; i++) begin
				// fill depends on every index bit
				ram[i] <= 32'hc0de_0000 ^ (32'(i) * 32'h0001_0003);
			end
		end else if (i_mem_write) begin
			ram[i_daddr[9:2]] <= i_wdata;
			if (log_count < LOG_DEPTH) begin
				log_addr[log_count] <= i_daddr;
				log_data[log_count] <= i_wdata;
			end
			log_count <= log_count + 1;
		end
	end

endmodule

`default_nettype wire

/* source/core.sv */
`default_nettype none

module core
	import core_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic [XLEN-1:0] i_instr,
	input  logic [XLEN-1:0] i_rdata,
	output logic [XLEN-1:0] o_iaddr,
	output logic [XLEN-1:0] o_daddr,
	output logic [XLEN-1:0] o_wdata,
	output logic            o_mem_write,
	output logic            o_mem_read
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	fwd_sel_e        fwd_a;
	fwd_sel_e        fwd_b;
	logic            stall;
	logic            flush;
	logic            redirect;
	logic [XLEN-1:0] target;
	logic [4:0]      id_rs;
	logic [4:0]      id_rt;
	logic [4:0]      ex_rd;
	logic            wb_we;
	logic [4:0]      wb_addr;
	logic [XLEN-1:0] wb_data;

	fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_instr(i_instr),
		.i_stall(stall), .i_redirect(redirect), .i_target(target),
		.o_pc(o_iaddr), .o_if_id(if_id)
	);

	decode u_decode (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_if_id(if_id),
		.i_stall(stall), .i_flush(flush),
		.i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
		.o_id_ex(id_ex), .o_rs_addr(id_rs), .o_rt_addr(id_rt)
	);

	// mem-stage forward is the ex_mem alu result
	execute u_execute (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_id_ex(id_ex),
		.i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
		.i_mem_result(ex_mem.alu_result), .i_wb_result(wb_data),
		.o_ex_mem(ex_mem), .o_redirect(redirect), .o_target(target),
		.o_rd_addr(ex_rd)
	);

	mem_stage u_mem_stage (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_ex_mem(ex_mem), .i_rdata(i_rdata),
		.o_daddr(o_daddr), .o_wdata(o_wdata),
		.o_mem_write(o_mem_write), .o_mem_read(o_mem_read),
		.o_wb_we(wb_we), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
	);

	hazard_unit u_hazard_unit (
		.i_id_rs(id_rs), .i_id_rt(id_rt),
		.i_ex_rs(id_ex.rs), .i_ex_rt(id_ex.rt), .i_ex_rd(ex_rd),
		.i_mem_rd(ex_mem.rd), .i_wb_rd(wb_addr),
		.i_ex_mem_read(id_ex.ctrl.mem_read),
		.i_mem_reg_write(ex_mem.reg_write), .i_wb_reg_write(wb_we),
		.i_redirect(redirect),
		.o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall), .o_flush(flush)
	);

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`default_nettype none

module mem_stage
	import core_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  ex_mem_t         i_ex_mem,
	input  logic [XLEN-1:0] i_rdata,
	output logic [XLEN-1:0] o_daddr,
	output logic [XLEN-1:0] o_wdata,
	output logic            o_mem_write,
	output logic            o_mem_read,
	output logic            o_wb_we,
	output logic [4:0]      o_wb_addr,
	output logic [XLEN-1:0] o_wb_data
);

	mem_wb_t mem_wb;

	// data port straight from ex_mem
	assign o_daddr     = i_ex_mem.alu_result;
	assign o_wdata     = i_ex_mem.store_data;
	assign o_mem_write = i_ex_mem.mem_write;
	assign o_mem_read  = i_ex_mem.mem_read;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= i_ex_mem.reg_write;
			mem_wb.mem_to_reg <= i_ex_mem.mem_to_reg;
			mem_wb.alu_result <= i_ex_mem.alu_result;
			mem_wb.load_data  <= i_rdata;
			mem_wb.rd         <= i_ex_mem.rd;
		end
	end

	// write-back select
	assign o_wb_we   = mem_wb.reg_write;
	assign o_wb_addr = mem_wb.rd;
	assign o_wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`default_nettype none

module hazard_unit
	import core_pkg::*;
(
	input  logic [4:0] i_id_rs,
	input  logic [4:0] i_id_rt,
	input  logic [4:0] i_ex_rs,
	input  logic [4:0] i_ex_rt,
	input  logic [4:0] i_ex_rd,
	input  logic [4:0] i_mem_rd,
	input  logic [4:0] i_wb_rd,
	input  logic       i_ex_mem_read,
	input  logic       i_mem_reg_write,
	input  logic       i_wb_reg_write,
	input  logic       i_redirect,
	output fwd_sel_e   o_fwd_a,
	output fwd_sel_e   o_fwd_b,
	output logic       o_stall,
	output logic       o_flush
);

	logic load_use;

	// memory stage is the younger result, so it wins
	always_comb begin
		o_fwd_a = FWD_REG;
		if (i_ex_rs != 5'd0 && i_mem_reg_write && i_mem_rd == i_ex_rs) begin
			o_fwd_a = FWD_MEM;
		end else if (i_ex_rs != 5'd0 && i_wb_reg_write && i_wb_rd == i_ex_rs) begin
			o_fwd_a = FWD_WB;
		end
		o_fwd_b = FWD_REG;
		if (i_ex_rt != 5'd0 && i_mem_reg_write && i_mem_rd == i_ex_rt) begin
			o_fwd_b = FWD_MEM;
		end else if (i_ex_rt != 5'd0 && i_wb_reg_write && i_wb_rd == i_ex_rt) begin
			o_fwd_b = FWD_WB;
		end
	end

	// conservative, rt counted even for i-type
	assign load_use = i_ex_mem_read && (i_ex_rd != 5'd0)
		&& (i_ex_rd == i_id_rs || i_ex_rd == i_id_rt);

	assign o_flush = i_redirect;
	assign o_stall = load_use && !i_redirect;

endmodule

`default_nettype wire

/* execute/execute.sv */
`default_nettype none

module execute
	import core_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  id_ex_t          i_id_ex,
	input  fwd_sel_e        i_fwd_a,
	input  fwd_sel_e        i_fwd_b,
	input  logic [XLEN-1:0] i_mem_result,
	input  logic [XLEN-1:0] i_wb_result,
	output ex_mem_t         o_ex_mem,
	output logic            o_redirect,
	output logic [XLEN-1:0] o_target,
	output logic [4:0]      o_rd_addr
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] rt_fwd;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_result;
	logic            taken;

	always_comb begin
		case (i_fwd_a)
			FWD_MEM: op_a = i_mem_result;
			FWD_WB:  op_a = i_wb_result;
			default: op_a = i_id_ex.rs_val;
		endcase
		case (i_fwd_b)
			FWD_MEM: rt_fwd = i_mem_result;
			FWD_WB:  rt_fwd = i_wb_result;
			default: rt_fwd = i_id_ex.rt_val;
		endcase
	end

	assign op_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rt_fwd;

	always_comb begin
		case (i_id_ex.ctrl.alu_op)
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_result = op_a + op_b;
		endcase
	end

	assign o_rd_addr = i_id_ex.ctrl.reg_dst_rd ? i_id_ex.rd : i_id_ex.rt;

	// branch compares the forwarded register values
	assign taken      = i_id_ex.ctrl.branch && (op_a == rt_fwd);
	assign o_redirect = taken || i_id_ex.ctrl.jump;
	assign o_target   = i_id_ex.ctrl.jump ? i_id_ex.jump_target
		: i_id_ex.pc4 + {i_id_ex.imm[XLEN-3:0], 2'b00};

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ex_mem <= '0;
		end else begin
			o_ex_mem.reg_write  <= i_id_ex.ctrl.reg_write;
			o_ex_mem.mem_to_reg <= i_id_ex.ctrl.mem_to_reg;
			o_ex_mem.mem_read   <= i_id_ex.ctrl.mem_read;
			o_ex_mem.mem_write  <= i_id_ex.ctrl.mem_write;
			o_ex_mem.alu_result <= alu_result;
			o_ex_mem.store_data <= rt_fwd;
			o_ex_mem.rd         <= o_rd_addr;
		end
	end

endmodule

`default_nettype wire

/* decode/decode.sv */
`default_nettype none

module decode
	import core_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  if_id_t          i_if_id,
	input  logic            i_stall,
	input  logic            i_flush,
	input  logic            i_wb_we,
	input  logic [4:0]      i_wb_addr,
	input  logic [XLEN-1:0] i_wb_data,
	output id_ex_t          o_id_ex,
	output logic [4:0]      o_rs_addr,
	output logic [4:0]      o_rt_addr
);

	logic [5:0]      op;
	logic [5:0]      funct;
	logic [4:0]      rs;
	logic [4:0]      rt;
	logic [4:0]      rd;
	logic [15:0]     imm16;
	logic [25:0]     index;
	logic [XLEN-1:0] rs_val;
	logic [XLEN-1:0] rt_val;
	ctrl_t           ctrl;
	id_ex_t          id_ex_d;

	assign op    = i_if_id.instr[31:26];
	assign rs    = i_if_id.instr[25:21];
	assign rt    = i_if_id.instr[20:16];
	assign rd    = i_if_id.instr[15:11];
	assign funct = i_if_id.instr[5:0];
	assign imm16 = i_if_id.instr[15:0];
	assign index = i_if_id.instr[25:0];

	assign o_rs_addr = rs;
	assign o_rt_addr = rt;

	reg_file u_reg_file (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_ra1    (rs),
		.i_ra2    (rt),
		.i_wa     (i_wb_addr),
		.i_we     (i_wb_we),
		.i_wd     (i_wb_data),
		.o_rd1    (rs_val),
		.o_rd2    (rt_val)
	);

	// control from opcode and funct, anything unknown stays a bubble
	always_comb begin
		ctrl = '0;
		case (op)
			OP_RTYPE: begin
				ctrl.reg_dst_rd = 1'b1;
				ctrl.reg_write  = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			OP_LW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.branch = 1'b1;
			end
			OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		id_ex_d.ctrl = (i_stall || i_flush || !i_if_id.valid) ? ctrl_t'('0) : ctrl;
		id_ex_d.pc4  = i_if_id.pc4;
		id_ex_d.rs_val = rs_val;
		id_ex_d.rt_val = rt_val;
		id_ex_d.imm  = {{(XLEN-16){imm16[15]}}, imm16};
		// upper pc bits of the delay-free successor
		id_ex_d.jump_target = {i_if_id.pc4[XLEN-1:28], index, 2'b00};
		id_ex_d.rs = rs;
		id_ex_d.rt = rt;
		id_ex_d.rd = rd;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex <= id_ex_d;
		end
	end

endmodule

`default_nettype wire

/* fetch/fetch.sv */
`default_nettype none

module fetch
	import core_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic [XLEN-1:0] i_instr,
	input  logic            i_stall,
	input  logic            i_redirect,
	input  logic [XLEN-1:0] i_target,
	output logic [XLEN-1:0] o_pc,
	output if_id_t          o_if_id
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc4;

	assign pc4  = pc + XLEN'(4);
	assign o_pc = pc;

	// redirect from execute wins over the load-use hold
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= RESET_PC;
		end else if (i_redirect) begin
			pc <= i_target;
		end else if (!i_stall) begin
			pc <= pc4;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_if_id <= '0;
		end else if (i_redirect) begin
			// wrong-path fetch becomes a bubble
			o_if_id.valid <= 1'b0;
		end else if (!i_stall) begin
			o_if_id.valid <= 1'b1;
			o_if_id.pc4   <= pc4;
			o_if_id.instr <= i_instr;
		end
	end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file
	import core_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic [4:0]      i_ra1,
	input  logic [4:0]      i_ra2,
	input  logic [4:0]      i_wa,
	input  logic            i_we,
	input  logic [XLEN-1:0] i_wd,
	output logic [XLEN-1:0] o_rd1,
	output logic [XLEN-1:0] o_rd2
);

	logic [XLEN-1:0] regs [32];
	logic            wr_en;

	// writes to r0 are dropped
	assign wr_en = i_we && (i_wa != 5'd0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[i_wa] <= i_wd;
		end
	end

	// write-first bypass
	assign o_rd1 = (i_ra1 == 5'd0) ? '0 : (wr_en && i_wa == i_ra1) ? i_wd : regs[i_ra1];
	assign o_rd2 = (i_ra2 == 5'd0) ? '0 : (wr_en && i_wa == i_ra2) ? i_wd : regs[i_ra2];

endmodule

`default_nettype wire

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

	parameter int XLEN = 32;

	// major opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDIU = 6'h09,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// r-type function field
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    reg_write;
		logic    branch;
		logic    jump;
	} ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc4;
		logic [XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc4;
		logic [XLEN-1:0] rs_val;
		logic [XLEN-1:0] rt_val;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] jump_target;
		logic [4:0]      rs;
		logic [4:0]      rt;
		logic [4:0]      rd;
	} id_ex_t;

	typedef struct packed {
		logic            reg_write;
		logic            mem_to_reg;
		logic            mem_read;
		logic            mem_write;
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
	} ex_mem_t;

	typedef struct packed {
		logic            reg_write;
		logic            mem_to_reg;
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] load_data;
		logic [4:0]      rd;
	} mem_wb_t;

endpackage

`default_nettype wire
